//--- vid_timing_pkg.sv
`default_nettype none

package vid_timing_pkg;

	// Raster counter widths, field bit sits above VC_W
	localparam int HC_W = 11;
	localparam int VC_W = 11;

	// Horizontal geometry, all values are pixel positions
	typedef struct packed {
		logic [HC_W-1:0] period;
		logic [HC_W-1:0] blank_beg;
		logic [HC_W-1:0] blank_end;
		logic [HC_W-1:0] sync_end;
		logic [HC_W-1:0] disp_beg;
		logic [HC_W-1:0] disp_end;
	} vid_hcfg_t;

	// Vertical geometry, all values are line numbers
	typedef struct packed {
		logic [VC_W-1:0] period;
		logic [VC_W-1:0] blank_beg;
		logic [VC_W-1:0] blank_end;
		logic [VC_W-1:0] sync_end;
		logic [VC_W-1:0] disp_beg;
		logic [VC_W-1:0] disp_end;
		logic [VC_W-1:0] int_line;
	} vid_vcfg_t;

	// Timing flag state, vwin is the vertical display window
	typedef struct packed {
		logic hblank;
		logic vblank;
		logic hsync;
		logic vsync;
		logic vwin;
		logic de;
		logic start;
		logic vint;
	} vid_flag_t;

	// All flags idle while reset or video disabled
	localparam vid_flag_t FLAGS_RST = '0;

endpackage

`default_nettype wire

//--- vid_reg_pkg.sv
`default_nettype none

package vid_reg_pkg;

	localparam int REG_AW = 5;
	localparam int RD_W = 16;

	// Register map
	// Writable timing registers sit low, read-back words from 0x10
	typedef enum logic [REG_AW-1:0] {
		REG_MODE = 5'h00,
		REG_HP   = 5'h01,
		REG_HBB  = 5'h02,
		REG_HBE  = 5'h03,
		REG_HS   = 5'h04,
		REG_HDB  = 5'h05,
		REG_HDE  = 5'h06,
		REG_VP   = 5'h07,
		REG_VBB  = 5'h08,
		REG_VBE  = 5'h09,
		REG_VS   = 5'h0a,
		REG_VDB  = 5'h0b,
		REG_VDE  = 5'h0c,
		REG_VI   = 5'h0d,
		REG_HC   = 5'h10,
		REG_VC   = 5'h11,
		REG_LPH  = 5'h12,
		REG_LPV  = 5'h13
	} vid_reg_addr_e;

	// Mode register, video enable
	localparam int MODE_EN_BIT = 0;

	// Light-pen event flag inside the LPH word
	localparam int LPH_EV_BIT = 11;

endpackage

`default_nettype wire

//--- vid_beat_if.sv
`timescale 1ns/1ps
`default_nettype none

interface vid_beat_if #(
	parameter int HC_W = 11,
	parameter int VC_W = 11
);

	// Raster position, vc carries the field bit on top
	logic [HC_W-1:0] hc;
	logic [VC_W:0]   vc;

	// Last pixel of a line, and of the last line
	logic line_end;
	logic frame_end;

	modport raster (
		output hc, vc, line_end, frame_end
	);

	modport sink (
		input hc, vc, line_end, frame_end
	);

endinterface

`default_nettype wire

//--- vid_count.sv
`timescale 1ns/1ps
`default_nettype none

module vid_count #(
	parameter int CNT_W = 11
) (
	input  wire logic             sys_clk,
	input  wire logic             resetl,
	input  wire logic             clr,
	input  wire logic             step,
	input  wire logic [CNT_W-1:0] period,
	output logic      [CNT_W-1:0] count,
	output logic                  at_end
);

	// Period match
	// Raw compare, the caller qualifies it
	assign at_end = (count == period);

	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			count <= '0;
		end else if (clr) begin
			// Held at zero while the axis is stopped
			count <= '0;
		end else if (step) begin
			if (at_end) begin
				// Wrap, so a full cycle is period+1 steps
				count <= '0;
			end else begin
				count <= count + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- vid_regs.sv
`timescale 1ns/1ps
`default_nettype none

module vid_regs
	import vid_timing_pkg::*;
	import vid_reg_pkg::*;
(
	input  wire logic          sys_clk,
	input  wire logic          resetl,
	input  wire logic          reg_wr,
	input  vid_reg_addr_e      reg_addr,
	input  wire logic [RD_W-1:0] reg_din,
	input  wire logic          reg_rd,
	output logic [RD_W-1:0]    rd_data,
	output vid_hcfg_t          hcfg,
	output vid_vcfg_t          vcfg,
	output logic               video_en,
	input  wire logic [RD_W-1:0] lph,
	input  wire logic [RD_W-1:0] lpv,
	vid_beat_if.sink           beat
);

	// Mode register, enable gates the whole generator
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			video_en <= 1'b0;
		end else if (reg_wr && reg_addr == REG_MODE) begin
			video_en <= reg_din[MODE_EN_BIT];
		end
	end

	// Geometry registers
	// Loaded at the edge after the write strobe
	always_ff @(posedge sys_clk) begin
		if (reg_wr) begin
			case (reg_addr)
				REG_HP:  hcfg.period    <= reg_din[HC_W-1:0];
				REG_HBB: hcfg.blank_beg <= reg_din[HC_W-1:0];
				REG_HBE: hcfg.blank_end <= reg_din[HC_W-1:0];
				REG_HS:  hcfg.sync_end  <= reg_din[HC_W-1:0];
				REG_HDB: hcfg.disp_beg  <= reg_din[HC_W-1:0];
				REG_HDE: hcfg.disp_end  <= reg_din[HC_W-1:0];
				REG_VP:  vcfg.period    <= reg_din[VC_W-1:0];
				REG_VBB: vcfg.blank_beg <= reg_din[VC_W-1:0];
				REG_VBE: vcfg.blank_end <= reg_din[VC_W-1:0];
				REG_VS:  vcfg.sync_end  <= reg_din[VC_W-1:0];
				REG_VDB: vcfg.disp_beg  <= reg_din[VC_W-1:0];
				REG_VDE: vcfg.disp_end  <= reg_din[VC_W-1:0];
				REG_VI:  vcfg.int_line  <= reg_din[VC_W-1:0];
				// Mode handled above, read-back words ignore writes
				default: ;
			endcase
		end
	end

	// Read-back bus
	// Live counters and light-pen words, zero elsewhere
	always_comb begin
		rd_data = '0;
		if (reg_rd) begin
			case (reg_addr)
				REG_HC:  rd_data = RD_W'(beat.hc);
				REG_VC:  rd_data = RD_W'(beat.vc);
				REG_LPH: rd_data = lph;
				REG_LPV: rd_data = lpv;
				default: rd_data = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- vid_raster.sv
`timescale 1ns/1ps
`default_nettype none

module vid_raster
	import vid_timing_pkg::*;
(
	input  wire logic  sys_clk,
	input  wire logic  resetl,
	input  wire logic  video_en,
	input  vid_hcfg_t  hcfg,
	input  vid_vcfg_t  vcfg,
	vid_beat_if.raster beat
);

	logic [HC_W-1:0] hc_cnt;
	logic [VC_W-1:0] vc_cnt;
	logic            h_at_end;
	logic            v_at_end;
	logic            line_end;
	logic            frame_end;
	logic            field;

	// Pixel counter, one step per clock
	vid_count #(.CNT_W(HC_W)) u_hcount (
		.sys_clk (sys_clk),
		.resetl  (resetl),
		.clr     (~video_en),
		.step    (video_en),
		.period  (hcfg.period),
		.count   (hc_cnt),
		.at_end  (h_at_end)
	);

	// Line counter, advances on horizontal wrap
	vid_count #(.CNT_W(VC_W)) u_vcount (
		.sys_clk (sys_clk),
		.resetl  (resetl),
		.clr     (~video_en),
		.step    (line_end),
		.period  (vcfg.period),
		.count   (vc_cnt),
		.at_end  (v_at_end)
	);

	assign line_end  = video_en & h_at_end;
	assign frame_end = line_end & v_at_end;

	// Field bit flips as the frame wraps
	always_ff @(posedge sys_clk) begin
		if (!resetl || !video_en) begin
			field <= 1'b0;
		end else if (frame_end) begin
			field <= ~field;
		end
	end

	assign beat.hc        = hc_cnt;
	assign beat.vc        = {field, vc_cnt};
	assign beat.line_end  = line_end;
	assign beat.frame_end = frame_end;

endmodule

`default_nettype wire

//--- vid_flags.sv
`timescale 1ns/1ps
`default_nettype none

module vid_flags
	import vid_timing_pkg::*;
(
	input  wire logic sys_clk,
	input  wire logic resetl,
	input  wire logic video_en,
	input  vid_hcfg_t hcfg,
	input  vid_vcfg_t vcfg,
	vid_beat_if.sink  beat,
	output logic      hblank,
	output logic      vblank,
	output logic      blank,
	output logic      hsync,
	output logic      vsync,
	output logic      de,
	output logic      start,
	output logic      vint
);

	vid_flag_t       fl_q;
	logic [VC_W-1:0] line;
	logic            hit_hbb;
	logic            hit_hbe;
	logic            hit_hs;
	logic            hit_hdb;
	logic            hit_hde;
	logic            hit_vbb;
	logic            hit_vbe;
	logic            hit_vs;
	logic            hit_vdb;
	logic            hit_vde;
	logic            hit_vi;
	logic            start_d;

	// Line number without the field bit
	assign line = beat.vc[VC_W-1:0];

	// Horizontal position matches
	assign hit_hbb = (beat.hc == hcfg.blank_beg);
	assign hit_hbe = (beat.hc == hcfg.blank_end);
	assign hit_hs  = (beat.hc == hcfg.sync_end);
	assign hit_hdb = (beat.hc == hcfg.disp_beg);
	assign hit_hde = (beat.hc == hcfg.disp_end);

	// Vertical line matches
	assign hit_vbb = (line == vcfg.blank_beg);
	assign hit_vbe = (line == vcfg.blank_end);
	assign hit_vs  = (line == vcfg.sync_end);
	assign hit_vdb = (line == vcfg.disp_beg);
	assign hit_vde = (line == vcfg.disp_end);
	assign hit_vi  = (line == vcfg.int_line);

	// Display start only inside the vertical window
	assign start_d = hit_hdb & fl_q.vwin;

	// Set/clear flip-flops
	// Set has priority when both match together
	always_ff @(posedge sys_clk) begin
		if (!resetl || !video_en) begin
			fl_q <= FLAGS_RST;
		end else begin
			fl_q.hblank <= hit_hbb | (fl_q.hblank & ~hit_hbe);
			fl_q.vblank <= hit_vbb | (fl_q.vblank & ~hit_vbe);
			// Sync pulses begin at the wrap
			fl_q.hsync  <= beat.line_end | (fl_q.hsync & ~hit_hs);
			fl_q.vsync  <= beat.frame_end | (fl_q.vsync & ~(hit_vs & beat.line_end));
			// Window moves only on line boundaries
			fl_q.vwin   <= (hit_vdb & beat.line_end) |
				(fl_q.vwin & ~(hit_vde & beat.line_end));
			fl_q.de     <= start_d | (fl_q.de & ~hit_hde);
			// One-cycle pulses
			fl_q.start  <= start_d;
			fl_q.vint   <= hit_vi & hit_hde;
		end
	end

	assign hblank = fl_q.hblank;
	assign vblank = fl_q.vblank;
	assign blank  = fl_q.hblank | fl_q.vblank;
	assign hsync  = fl_q.hsync;
	assign vsync  = fl_q.vsync;
	assign de     = fl_q.de;
	assign start  = fl_q.start;
	assign vint   = fl_q.vint;

endmodule

`default_nettype wire

//--- vid_lightpen.sv
`timescale 1ns/1ps
`default_nettype none

module vid_lightpen
	import vid_reg_pkg::*;
#(
	parameter int HC_W = 11,
	parameter int VC_W = 11
) (
	input  wire logic       sys_clk,
	input  wire logic       resetl,
	input  wire logic       lp,
	vid_beat_if.sink        beat,
	output logic [RD_W-1:0] lph,
	output logic [RD_W-1:0] lpv
);

	logic            lp_meta;
	logic            lp_sync;
	logic            lp_ld;
	logic            lp_event;
	logic [HC_W-1:0] lph_q;
	logic [VC_W:0]   lpv_q;

	// Two-stage synchronizer on the pen input
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			lp_meta <= 1'b0;
			lp_sync <= 1'b0;
		end else begin
			lp_meta <= lp;
			lp_sync <= lp_meta;
		end
	end

	// Rising edge, seen one clock after the input settles
	assign lp_ld = lp_meta & ~lp_sync;

	// Position latch, includes the field bit
	always_ff @(posedge sys_clk) begin
		if (lp_ld) begin
			lph_q <= beat.hc;
			lpv_q <= beat.vc;
		end
	end

	// Event flag, a new hit beats the frame-end clear
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			lp_event <= 1'b0;
		end else begin
			lp_event <= lp_ld | (lp_event & ~beat.frame_end);
		end
	end

	always_comb begin
		lph = '0;
		lph[HC_W-1:0] = lph_q;
		lph[LPH_EV_BIT] = lp_event;
	end

	assign lpv = RD_W'(lpv_q);

endmodule

`default_nettype wire

//--- vid_top.sv
`timescale 1ns/1ps
`default_nettype none

module vid_top
	import vid_timing_pkg::*;
	import vid_reg_pkg::*;
(
	input  wire logic            sys_clk,
	input  wire logic            resetl,
	input  wire logic            reg_wr,
	input  vid_reg_addr_e        reg_addr,
	input  wire logic [RD_W-1:0] reg_din,
	input  wire logic            reg_rd,
	output logic      [RD_W-1:0] rd_data,
	input  wire logic            lp,
	output logic                 hblank,
	output logic                 vblank,
	output logic                 blank,
	output logic                 hsync,
	output logic                 vsync,
	output logic                 de,
	output logic                 start,
	output logic                 vint
);

	vid_hcfg_t       hcfg;
	vid_vcfg_t       vcfg;
	logic            video_en;
	logic [RD_W-1:0] lph;
	logic [RD_W-1:0] lpv;

	// Raster position shared by all consumers
	vid_beat_if #(.HC_W(HC_W), .VC_W(VC_W)) beat ();

	// Register file and read-back
	vid_regs u_regs (
		.sys_clk  (sys_clk),
		.resetl   (resetl),
		.reg_wr   (reg_wr),
		.reg_addr (reg_addr),
		.reg_din  (reg_din),
		.reg_rd   (reg_rd),
		.rd_data  (rd_data),
		.hcfg     (hcfg),
		.vcfg     (vcfg),
		.video_en (video_en),
		.lph      (lph),
		.lpv      (lpv),
		.beat     (beat.sink)
	);

	vid_raster u_raster (
		.sys_clk  (sys_clk),
		.resetl   (resetl),
		.video_en (video_en),
		.hcfg     (hcfg),
		.vcfg     (vcfg),
		.beat     (beat.raster)
	);

	// Blanking, sync and display flags
	vid_flags u_flags (
		.sys_clk  (sys_clk),
		.resetl   (resetl),
		.video_en (video_en),
		.hcfg     (hcfg),
		.vcfg     (vcfg),
		.beat     (beat.sink),
		.hblank   (hblank),
		.vblank   (vblank),
		.blank    (blank),
		.hsync    (hsync),
		.vsync    (vsync),
		.de       (de),
		.start    (start),
		.vint     (vint)
	);

	vid_lightpen #(.HC_W(HC_W), .VC_W(VC_W)) u_lightpen (
		.sys_clk (sys_clk),
		.resetl  (resetl),
		.lp      (lp),
		.beat    (beat.sink),
		.lph     (lph),
		.lpv     (lpv)
	);

endmodule

`default_nettype wire

//--- tb_clk.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk (
	output logic sys_clk,
	output logic resetl
);

	// 4 ns period
	initial begin
		sys_clk = 1'b0;
		forever #2 sys_clk = ~sys_clk;
	end

	// Reset held for five rising edges, released on a falling edge
	initial begin
		resetl = 1'b0;
		repeat (5) @(posedge sys_clk);
		@(negedge sys_clk);
		resetl = 1'b1;
	end

endmodule

`default_nettype wire

//--- tb_vid.sv
`timescale 1ns/1ps
`default_nettype none

module tb_vid
	import vid_reg_pkg::*;
;

	// Largest geometry the random setup can pick, 36 pixels by 12 lines
	localparam int MAX_FRAME = 36 * 12;
	// Two configurations of three frames, light pen and idle phases on top
	localparam int RUN_CYCLES = 12 * MAX_FRAME + 1000;

	logic            sys_clk;
	logic            resetl;
	logic            reg_wr;
	vid_reg_addr_e   reg_addr;
	logic [RD_W-1:0] reg_din;
	logic            reg_rd;
	logic [RD_W-1:0] rd_data;
	logic            lp;
	logic            hblank;
	logic            vblank;
	logic            blank;
	logic            hsync;
	logic            vsync;
	logic            de;
	logic            start;
	logic            vint;

	int          err_val;
	int          err_per;
	logic [31:0] seed;

	// Register shadow built from the bus
	logic [RD_W-1:0] cfg_m [0:31];
	logic            en_m;
	logic [10:0]     m_hp, m_hbb, m_hbe, m_hs, m_hdb, m_hde;
	logic [10:0]     m_vp, m_vbb, m_vbe, m_vs, m_vdb, m_vde, m_vi;

	// Raster model
	logic [10:0] hc_m;
	logic [10:0] ln_m;
	logic        field_m;
	logic        lines_seen;
	logic        frames_seen;
	logic        fe_m;
	logic        win_m;

	// Expected flag outputs
	logic exp_hb, exp_vb, exp_hs, exp_vs, exp_de, exp_st, exp_vi;

	// Light-pen model
	logic        lp_s1, lp_s2, lp_ld_m, ev_m, lp_valid;
	logic [10:0] lph_m;
	logic [11:0] lpv_m;

	logic [RD_W-1:0] exp_rd;
	logic            rd_chk;

	tb_clk u_clk (
		.sys_clk (sys_clk),
		.resetl  (resetl)
	);

	vid_top u_dut (
		.sys_clk  (sys_clk),
		.resetl   (resetl),
		.reg_wr   (reg_wr),
		.reg_addr (reg_addr),
		.reg_din  (reg_din),
		.reg_rd   (reg_rd),
		.rd_data  (rd_data),
		.lp       (lp),
		.hblank   (hblank),
		.vblank   (vblank),
		.blank    (blank),
		.hsync    (hsync),
		.vsync    (vsync),
		.de       (de),
		.start    (start),
		.vint     (vint)
	);

	function automatic logic [31:0] rand_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	assign en_m  = cfg_m[REG_MODE][MODE_EN_BIT];
	assign m_hp  = cfg_m[REG_HP][10:0];
	assign m_hbb = cfg_m[REG_HBB][10:0];
	assign m_hbe = cfg_m[REG_HBE][10:0];
	assign m_hs  = cfg_m[REG_HS][10:0];
	assign m_hdb = cfg_m[REG_HDB][10:0];
	assign m_hde = cfg_m[REG_HDE][10:0];
	assign m_vp  = cfg_m[REG_VP][10:0];
	assign m_vbb = cfg_m[REG_VBB][10:0];
	assign m_vbe = cfg_m[REG_VBE][10:0];
	assign m_vs  = cfg_m[REG_VS][10:0];
	assign m_vdb = cfg_m[REG_VDB][10:0];
	assign m_vde = cfg_m[REG_VDE][10:0];
	assign m_vi  = cfg_m[REG_VI][10:0];

	// Last pixel of the last line
	assign fe_m = en_m && hc_m == m_hp && ln_m == m_vp;
	// Vertical window opens after line VDB and closes after line VDE
	assign win_m = ln_m > m_vdb && ln_m <= m_vde;
	assign lp_ld_m = lp_s1 & ~lp_s2;

	// Writes land at the edge after the strobe, mode is the only reset value
	always @(posedge sys_clk) begin
		if (!resetl) begin
			cfg_m[REG_MODE] <= '0;
		end else if (reg_wr) begin
			cfg_m[reg_addr] <= reg_din;
		end
	end

	// Position model, a line is HP+1 pixels and a frame VP+1 lines
	always @(posedge sys_clk) begin
		if (!resetl || !en_m) begin
			hc_m        <= '0;
			ln_m        <= '0;
			field_m     <= 1'b0;
			lines_seen  <= 1'b0;
			frames_seen <= 1'b0;
		end else if (hc_m == m_hp) begin
			hc_m       <= '0;
			lines_seen <= 1'b1;
			if (ln_m == m_vp) begin
				ln_m        <= '0;
				field_m     <= ~field_m;
				frames_seen <= 1'b1;
			end else begin
				ln_m <= ln_m + 1'b1;
			end
		end else begin
			hc_m <= hc_m + 1'b1;
		end
	end

	// Flag windows, each flag follows its match by one cycle
	always @(posedge sys_clk) begin
		if (!resetl || !en_m) begin
			exp_hb <= 1'b0;
			exp_vb <= 1'b0;
			exp_hs <= 1'b0;
			exp_vs <= 1'b0;
			exp_de <= 1'b0;
			exp_st <= 1'b0;
			exp_vi <= 1'b0;
		end else begin
			exp_hb <= hc_m >= m_hbb && hc_m < m_hbe;
			exp_vb <= ln_m >= m_vbb && ln_m < m_vbe;
			// Sync runs from the line wrap up to HS
			exp_hs <= hc_m == m_hp || (lines_seen && hc_m < m_hs);
			// Vertical sync from frame end through the end of line VS
			exp_vs <= fe_m ||
				(frames_seen && ln_m <= m_vs && !(ln_m == m_vs && hc_m == m_hp));
			exp_st <= win_m && hc_m == m_hdb;
			exp_de <= win_m && hc_m >= m_hdb && hc_m < m_hde;
			exp_vi <= ln_m == m_vi && hc_m == m_hde;
		end
	end

	// Pen edge after two sampling stages latches the position
	always @(posedge sys_clk) begin
		if (!resetl) begin
			lp_s1    <= 1'b0;
			lp_s2    <= 1'b0;
			ev_m     <= 1'b0;
			lp_valid <= 1'b0;
		end else begin
			lp_s1 <= lp;
			lp_s2 <= lp_s1;
			ev_m  <= lp_ld_m | (ev_m & ~fe_m);
			if (lp_ld_m) begin
				lph_m    <= hc_m;
				lpv_m    <= {field_m, ln_m};
				lp_valid <= 1'b1;
			end
		end
	end

	// Expected read-back word
	always_comb begin
		exp_rd = '0;
		rd_chk = 1'b1;
		if (reg_rd) begin
			case (reg_addr)
				REG_HC:  exp_rd = RD_W'(hc_m);
				REG_VC:  exp_rd = RD_W'({field_m, ln_m});
				REG_LPH: begin
					exp_rd = RD_W'({ev_m, lph_m});
					rd_chk = lp_valid;
				end
				REG_LPV: begin
					exp_rd = RD_W'(lpv_m);
					rd_chk = lp_valid;
				end
				default: exp_rd = '0;
			endcase
		end
	end

	a_rd: assert property (@(posedge sys_clk) disable iff (!resetl)
		!rd_chk || rd_data == exp_rd)
	else begin
		err_val++;
		$display("[FAIL] rd_data exp %h got %h", $sampled(exp_rd), $sampled(rd_data));
	end

	a_hblank: assert property (@(posedge sys_clk) disable iff (!resetl) hblank == exp_hb)
	else begin
		err_val++;
		$display("[FAIL] hblank exp %h got %h", $sampled(exp_hb), $sampled(hblank));
	end

	a_vblank: assert property (@(posedge sys_clk) disable iff (!resetl) vblank == exp_vb)
	else begin
		err_val++;
		$display("[FAIL] vblank exp %h got %h", $sampled(exp_vb), $sampled(vblank));
	end

	a_blank: assert property (@(posedge sys_clk) disable iff (!resetl)
		blank == (exp_hb | exp_vb))
	else begin
		err_val++;
		$display("[FAIL] blank exp %h got %h",
			$sampled(exp_hb | exp_vb), $sampled(blank));
	end

	a_hsync: assert property (@(posedge sys_clk) disable iff (!resetl) hsync == exp_hs)
	else begin
		err_val++;
		$display("[FAIL] hsync exp %h got %h", $sampled(exp_hs), $sampled(hsync));
	end

	a_vsync: assert property (@(posedge sys_clk) disable iff (!resetl) vsync == exp_vs)
	else begin
		err_val++;
		$display("[FAIL] vsync exp %h got %h", $sampled(exp_vs), $sampled(vsync));
	end

	a_de: assert property (@(posedge sys_clk) disable iff (!resetl) de == exp_de)
	else begin
		err_val++;
		$display("[FAIL] de exp %h got %h", $sampled(exp_de), $sampled(de));
	end

	a_start: assert property (@(posedge sys_clk) disable iff (!resetl) start == exp_st)
	else begin
		err_val++;
		$display("[FAIL] start exp %h got %h", $sampled(exp_st), $sampled(start));
	end

	a_vint: assert property (@(posedge sys_clk) disable iff (!resetl) vint == exp_vi)
	else begin
		err_val++;
		$display("[FAIL] vint exp %h got %h", $sampled(exp_vi), $sampled(vint));
	end

	// Spacing of hsync rises and vint pulses, sampled mid-cycle
	int   cyc;
	int   hs_last;
	int   vi_last;
	logic hs_prev;
	initial begin
		cyc     = 0;
		hs_last = -1;
		vi_last = -1;
		hs_prev = 1'b0;
	end

	always @(negedge sys_clk) begin
		cyc++;
		if (!en_m) begin
			hs_last = -1;
			vi_last = -1;
		end else begin
			if (hsync && !hs_prev) begin
				if (hs_last >= 0 && cyc - hs_last != int'(m_hp) + 1) begin
					err_per++;
					$display("[FAIL] hsync period exp %h got %h",
						int'(m_hp) + 1, cyc - hs_last);
				end
				hs_last = cyc;
			end
			if (vint) begin
				if (vi_last >= 0 &&
					cyc - vi_last != (int'(m_hp) + 1) * (int'(m_vp) + 1)) begin
					err_per++;
					$display("[FAIL] vint period exp %h got %h",
						(int'(m_hp) + 1) * (int'(m_vp) + 1), cyc - vi_last);
				end
				vi_last = cyc;
			end
		end
		hs_prev = hsync;
	end

	// Caller sits on a falling edge
	task automatic write_reg(input vid_reg_addr_e addr, input logic [RD_W-1:0] data);
		reg_wr   = 1'b1;
		reg_addr = addr;
		reg_din  = data;
		@(negedge sys_clk);
		reg_wr = 1'b0;
	endtask

	// Random geometry with begin below end below the period
	task automatic program_geometry();
		logic [10:0] hp;
		logic [10:0] hbb;
		logic [10:0] hdb;
		logic [10:0] vp;
		logic [10:0] vbb;
		logic [10:0] vdb;
		hp  = 11'(20 + rand_next() % 16);
		hbb = 11'(1 + rand_next() % 4);
		hdb = 11'(2 + rand_next() % 5);
		vp  = 11'(6 + rand_next() % 6);
		vbb = 11'(rand_next() % 2);
		vdb = 11'(1 + rand_next() % 2);
		write_reg(REG_HP, RD_W'(hp));
		write_reg(REG_HBB, RD_W'(hbb));
		write_reg(REG_HBE, RD_W'(hbb + 1 + rand_next() % 6));
		write_reg(REG_HS, RD_W'(1 + rand_next() % 8));
		write_reg(REG_HDB, RD_W'(hdb));
		write_reg(REG_HDE, RD_W'(hdb + 1 + rand_next() % 8));
		write_reg(REG_VP, RD_W'(vp));
		write_reg(REG_VBB, RD_W'(vbb));
		write_reg(REG_VBE, RD_W'(vbb + 1 + rand_next() % 3));
		write_reg(REG_VS, RD_W'(rand_next() % 4));
		write_reg(REG_VDB, RD_W'(vdb));
		write_reg(REG_VDE, RD_W'(vdb + 1 + rand_next() % 3));
		write_reg(REG_VI, RD_W'(rand_next() % (vp + 1)));
	endtask

	// Counters, a writable address and an unmapped one
	task automatic drive_random_read();
		logic [31:0] r;
		r      = rand_next();
		reg_rd = r[8];
		case (r[2:0] % 5)
			0: reg_addr = REG_HC;
			1: reg_addr = REG_VC;
			2: reg_addr = REG_HP;
			3: reg_addr = vid_reg_addr_e'(5'h1f);
			default: reg_addr = REG_MODE;
		endcase
	endtask

	// Frames counted by vint pulses, watchdog bounds the wait
	task automatic run_frames(input int n);
		int k;
		k = 0;
		while (k < n) begin
			@(negedge sys_clk);
			drive_random_read();
			if (vint) begin
				k++;
			end
		end
		reg_rd = 1'b0;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(negedge sys_clk);
			drive_random_read();
		end
		reg_rd = 1'b0;
	endtask

	// Pen hit at a random time, LPH checked against the HC read on that cycle
	task automatic pen_hit();
		logic [10:0] hc_rd;
		logic [10:0] hc_exp;
		repeat (int'(rand_next() % 200)) @(negedge sys_clk);
		lp       = 1'b1;
		reg_rd   = 1'b1;
		reg_addr = REG_HC;
		#1;
		hc_rd  = rd_data[10:0];
		hc_exp = (hc_rd == m_hp) ? 11'd0 : hc_rd + 1'b1;
		@(negedge sys_clk);
		reg_rd = 1'b0;
		// Latch lands on the second rising edge after the drive
		@(negedge sys_clk);
		reg_rd   = 1'b1;
		reg_addr = REG_LPH;
		#1;
		if (rd_data[10:0] != hc_exp || !rd_data[LPH_EV_BIT]) begin
			err_val++;
			$display("[FAIL] lph exp %h got %h", {1'b1, hc_exp}, rd_data[11:0]);
		end
		@(negedge sys_clk);
		// Line and field of the hit, compared with the model on read-back
		reg_addr = REG_LPV;
		@(negedge sys_clk);
		reg_rd = 1'b0;
		lp     = 1'b0;
		// Event flag drops after the next frame end
		while (!fe_m) @(negedge sys_clk);
		@(negedge sys_clk);
		reg_rd   = 1'b1;
		reg_addr = REG_LPH;
		#1;
		if (rd_data[LPH_EV_BIT]) begin
			err_val++;
			$display("Light-pen event flag still set after the frame end");
		end
		@(negedge sys_clk);
		reg_rd = 1'b0;
	endtask

	initial begin
		#(RUN_CYCLES * 4);
		$display("Watchdog expired before the test sequence completed");
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		seed     = 32'hde9cbc83;
		err_val  = 0;
		err_per  = 0;
		reg_wr   = 1'b0;
		reg_addr = REG_MODE;
		reg_din  = '0;
		reg_rd   = 1'b0;
		lp       = 1'b0;
		@(posedge resetl);
		@(negedge sys_clk);
		// Disabled after reset, reads and flags stay at zero
		idle_cycles(40);
		program_geometry();
		write_reg(REG_MODE, RD_W'(1) << MODE_EN_BIT);
		run_frames(3);
		pen_hit();
		// Disable mid-frame
		idle_cycles(int'(rand_next() % 50));
		write_reg(REG_MODE, '0);
		idle_cycles(50);
		program_geometry();
		write_reg(REG_MODE, RD_W'(1) << MODE_EN_BIT);
		run_frames(3);
		pen_hit();
		idle_cycles(10);
		$display("Errors: %0d value, %0d period", err_val, err_per);
		if (err_val == 0 && err_per == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
vid_timing_pkg.sv
vid_reg_pkg.sv
vid_beat_if.sv
vid_count.sv
vid_regs.sv
vid_raster.sv
vid_flags.sv
vid_lightpen.sv
vid_top.sv
tb_clk.sv
tb_vid.sv

//--- Bender.yml
package:
  name: vid_timing

sources:
  - vid_timing_pkg.sv
  - vid_reg_pkg.sv
  - vid_beat_if.sv
  - vid_count.sv
  - vid_regs.sv
  - vid_raster.sv
  - vid_flags.sv
  - vid_lightpen.sv
  - vid_top.sv
  - target: simulation
    files:
      - tb_clk.sv
      - tb_vid.sv
